/* sources.f */
+incdir+design
design/vic_pkg.sv
design/irq_input_stage.sv
design/irq_line.sv
design/irq_priority.sv
design/vic_ctrl.sv
design/vic_top.sv
test/vic_properties.sv
test/vic_tb.sv

/* Makefile */
# Verilator build and run for the interrupt controller testbench

VERILATOR ?= verilator
TOP       ?= vic_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FILELIST := sources.f
SOURCES  := $(shell grep -v '^+' $(FILELIST))
HEADERS  := $(wildcard design/*.svh)
SIM      := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# Pass or fail is decided from the log
run: $(SIM)
	$(SIM) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* test/vic_tb.sv */
`default_nettype none

`include "vic_cfg.svh"

module vic_tb
   import vic_pkg::*;
();

   // Five directed tests plus the random iterations
   localparam int NUM_RAND      = 40;
   localparam int NUM_ITER      = NUM_RAND + 5;
   localparam int CYCLE_LIMIT   = 200 * NUM_ITER;
   // Longest wait for one redirect
   localparam int REDIRECT_WAIT = 100;

   logic      clk;
   logic      rst;
   irq_mask_t i_irq;
   logic      i_en_we;
   irq_mask_t i_en_data;
   addr_t     i_pc;
   cc_t       i_cc;
   logic      i_not_flush;
   logic      i_reti;
   logic      o_redirect;
   addr_t     o_target_pc;
   logic      o_cc_restore;
   cc_t       o_cc;

   // Reference model
   irq_mask_t model_mask;
   irq_mask_t model_pend;
   addr_t     model_pc;
   cc_t       model_cc;
   logic      in_isr;
   // Inputs sampled by the most recent rising clock
   addr_t     prev_pc;
   cc_t       prev_cc;
   logic      prev_nf;
   // Random bubbles while waiting for a handler entry
   logic      flush_jitter;

   int unsigned seed;
   int errors;
   int err_start;
   int tests_pass;
   int tests_fail;
   int cycle_count;

   vic_top i_dut (
      .clk         (clk),
      .rst         (rst),
      .i_irq       (i_irq),
      .i_en_we     (i_en_we),
      .i_en_data   (i_en_data),
      .i_pc        (i_pc),
      .i_cc        (i_cc),
      .i_not_flush (i_not_flush),
      .i_reti      (i_reti),
      .o_redirect  (o_redirect),
      .o_target_pc (o_target_pc),
      .o_cc_restore(o_cc_restore),
      .o_cc        (o_cc)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Watchdog
   initial
   begin
      cycle_count = 0;
      while (cycle_count < CYCLE_LIMIT)
      begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Run stopped at the limit of %0d cycles", CYCLE_LIMIT);
      $display("TEST FAIL");
      $finish;
   end

   ////////////////////
   // Model rules
   ////////////////////

   // Lowest numbered line wins
   function automatic irq_id_t lowest_pending(input irq_mask_t m);
      for (int i = 0; i < `VIC_NUM_IRQ; i++)
      begin
         if (m[i])
            return irq_id_t'(i);
      end
      return '0;
   endfunction

   // Slot base plus line number times slot size
   function automatic addr_t vector_for(input irq_id_t id);
      return addr_t'(`VIC_ISR_BASE) + addr_t'(id) * (32'd1 << `VIC_VEC_SHIFT);
   endfunction

   ////////////////////
   // Helpers
   ////////////////////

   task automatic check_hex(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act)
      begin
         $display("ERROR %s expected %h got %h", name, exp, act);
         errors++;
      end
   endtask

   // One clock, then fresh PC and CC on the falling edge
   task automatic step();
      prev_pc = i_pc;
      prev_cc = i_cc;
      prev_nf = i_not_flush;
      @(negedge clk);
      i_pc    = $urandom() & 32'hffff_fffc;
      i_cc    = cc_t'($urandom());
      i_reti  = 1'b0;
      i_en_we = 1'b0;
   endtask

   // Cycles where no redirect may appear
   task automatic idle_cycles(input int n);
      repeat (n)
      begin
         step();
         check_hex("o_redirect", 32'd0, 32'(o_redirect));
         check_hex("o_cc_restore", 32'd0, 32'(o_cc_restore));
      end
   endtask

   task automatic write_mask(input irq_mask_t m);
      i_en_we    = 1'b1;
      i_en_data  = m;
      model_mask = m;
      step();
   endtask

   // Only enabled rising lines become pending
   task automatic raise_lines(input irq_mask_t lines);
      model_pend = model_pend | (lines & ~i_irq & model_mask);
      i_irq      = i_irq | lines;
   endtask

   // Lines low long enough to clear the edge pipeline
   task automatic drop_lines();
      i_irq = '0;
      idle_cycles(4);
   endtask

   task automatic wait_redirect(output int waited);
      waited = 0;
      do
      begin
         step();
         waited++;
         if (flush_jitter)
            i_not_flush = logic'($urandom_range(0, 1));
      end while (!o_redirect && waited < REDIRECT_WAIT);
      if (!o_redirect)
      begin
         $display("No redirect arrived within %0d cycles", waited);
         errors++;
      end
   endtask

   // Handler entry, context taken from the sample before the redirect
   task automatic take_entry(output int waited);
      irq_id_t id;
      id = lowest_pending(model_pend);
      wait_redirect(waited);
      check_hex("o_target_pc", vector_for(id), o_target_pc);
      check_hex("o_cc_restore", 32'd0, 32'(o_cc_restore));
      if (!prev_nf)
      begin
         $display("Handler was entered while execute held a bubble");
         errors++;
      end
      model_pc       = prev_pc;
      model_cc       = prev_cc;
      model_pend[id] = 1'b0;
      in_isr         = 1'b1;
   endtask

   // Redirect is due on the very next cycle
   task automatic return_from_isr();
      irq_id_t id;
      i_reti = 1'b1;
      step();
      check_hex("o_redirect", 32'd1, 32'(o_redirect));
      if (model_pend != '0)
      begin
         // Tail chain keeps the saved context
         id = lowest_pending(model_pend);
         check_hex("o_target_pc", vector_for(id), o_target_pc);
         check_hex("o_cc_restore", 32'd0, 32'(o_cc_restore));
         model_pend[id] = 1'b0;
      end
      else
      begin
         check_hex("o_target_pc", model_pc, o_target_pc);
         check_hex("o_cc_restore", 32'd1, 32'(o_cc_restore));
         check_hex("o_cc", 32'(model_cc), 32'(o_cc));
         in_isr = 1'b0;
      end
   endtask

   task automatic mark_start();
      err_start = errors;
   endtask

   task automatic report_test(input string name);
      if (errors == err_start)
      begin
         tests_pass++;
         $display("%s passed", name);
      end
      else
      begin
         tests_fail++;
         $display("%s failed with %0d errors", name, errors - err_start);
      end
   endtask

   ////////////////////
   // Tests
   ////////////////////

   // Lines toggle with every line masked
   task automatic reset_quiet();
      mark_start();
      check_hex("o_redirect", 32'd0, 32'(o_redirect));
      check_hex("o_cc_restore", 32'd0, 32'(o_cc_restore));
      repeat (30)
      begin
         i_irq = irq_mask_t'($urandom());
         idle_cycles(1);
      end
      drop_lines();
      report_test("reset_quiet");
   endtask

   task automatic single_irq();
      irq_id_t id;
      int      waited;
      id = irq_id_t'($urandom_range(0, `VIC_NUM_IRQ - 1));
      mark_start();
      i_not_flush = 1'b1;
      write_mask(irq_mask_t'(1) << id);
      raise_lines(irq_mask_t'(1) << id);
      take_entry(waited);
      // First step only reaches the sampling clock
      check_hex("redirect latency", 32'd5, 32'(waited - 1));
      idle_cycles(1);
      return_from_isr();
      drop_lines();
      report_test("single_irq");
   endtask

   task automatic flush_stall();
      irq_id_t id;
      int      waited;
      id = irq_id_t'($urandom_range(0, `VIC_NUM_IRQ - 1));
      mark_start();
      i_not_flush = 1'b0;
      write_mask(irq_mask_t'($urandom()) | (irq_mask_t'(1) << id));
      raise_lines(irq_mask_t'(1) << id);
      // Long enough to park in WAIT_SLOT
      idle_cycles(int'($urandom_range(6, 30)));
      i_not_flush = 1'b1;
      take_entry(waited);
      check_hex("redirect delay", 32'd1, 32'(waited));
      idle_cycles(int'($urandom_range(1, 4)));
      return_from_isr();
      drop_lines();
      report_test("flush_stall");
   endtask

   task automatic plain_return();
      irq_id_t id;
      int      waited;
      id = irq_id_t'($urandom_range(0, `VIC_NUM_IRQ - 1));
      mark_start();
      i_not_flush = 1'b1;
      write_mask(irq_mask_t'(1) << id);
      raise_lines(irq_mask_t'(1) << id);
      take_entry(waited);
      // Handler body
      idle_cycles(int'($urandom_range(2, 8)));
      return_from_isr();
      idle_cycles(3);
      drop_lines();
      report_test("plain_return");
   endtask

   task automatic tail_chain();
      irq_id_t a;
      irq_id_t b;
      irq_id_t tmp;
      int      waited;
      a = irq_id_t'($urandom_range(0, `VIC_NUM_IRQ - 1));
      do
         b = irq_id_t'($urandom_range(0, `VIC_NUM_IRQ - 1));
      while (b == a);
      if (a > b)
      begin
         tmp = a;
         a   = b;
         b   = tmp;
      end
      mark_start();
      i_not_flush = 1'b1;
      write_mask(irq_mask_t'($urandom()) | (irq_mask_t'(1) << a) | (irq_mask_t'(1) << b));
      raise_lines((irq_mask_t'(1) << a) | (irq_mask_t'(1) << b));
      take_entry(waited);
      // Lower line first
      check_hex("o_target_pc", vector_for(a), o_target_pc);
      idle_cycles(int'($urandom_range(1, 3)));
      return_from_isr();
      check_hex("o_target_pc", vector_for(b), o_target_pc);
      idle_cycles(int'($urandom_range(1, 3)));
      // Back to the original program
      return_from_isr();
      drop_lines();
      report_test("tail_chain");
   endtask

   task automatic random_runs();
      irq_mask_t lines;
      int        stall;
      int        waited;
      mark_start();
      flush_jitter = 1'b1;
      for (int n = 0; n < NUM_RAND; n++)
      begin
         write_mask(irq_mask_t'($urandom()));
         lines       = irq_mask_t'($urandom());
         stall       = int'($urandom_range(0, 12));
         i_not_flush = (stall == 0);
         raise_lines(lines);
         idle_cycles(stall);
         i_not_flush = 1'b1;
         if (model_pend == '0)
            // Masked lines never vector
            idle_cycles(20);
         else
         begin
            take_entry(waited);
            while (in_isr)
            begin
               idle_cycles(int'($urandom_range(1, 4)));
               return_from_isr();
            end
         end
         drop_lines();
      end
      report_test("random_runs");
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial
   begin
      seed         = $urandom(94);
      rst          = 1'b1;
      i_irq        = '0;
      i_en_we      = 1'b0;
      i_en_data    = '0;
      i_pc         = '0;
      i_cc         = '0;
      i_not_flush  = 1'b1;
      i_reti       = 1'b0;
      model_mask   = '0;
      model_pend   = '0;
      model_pc     = '0;
      model_cc     = '0;
      in_isr       = 1'b0;
      prev_pc      = '0;
      prev_cc      = '0;
      prev_nf      = 1'b0;
      flush_jitter = 1'b0;
      errors       = 0;
      err_start    = 0;
      tests_pass   = 0;
      tests_fail   = 0;
      repeat (5) @(negedge clk);
      rst = 1'b0;

      reset_quiet();
      single_irq();
      flush_stall();
      plain_return();
      tail_chain();
      random_runs();

      $display("Tests passed %0d failed %0d", tests_pass, tests_fail);
      if (tests_fail == 0 && errors == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* test/vic_properties.sv */
`default_nettype none

module vic_properties
(
   input logic clk,
   input logic rst,
   input logic i_req,
   input logic o_ack,
   input logic o_redirect,
   input logic o_cc_restore
);

   ////////////////////
   // Handshake
   ////////////////////

   // Acknowledge only names a live request
   ack_needs_req : assert property (@(posedge clk) disable iff (rst) o_ack |-> i_req)
      else $error("o_ack high while i_req low");

   // Single cycle acknowledge
   ack_is_pulse : assert property (@(posedge clk) disable iff (rst) o_ack |=> !o_ack)
      else $error("o_ack high two cycles in a row");

   ////////////////////
   // Redirect
   ////////////////////

   // Redirect is a one cycle pulse
   redirect_is_pulse : assert property (@(posedge clk) disable iff (rst)
      o_redirect |=> !o_redirect)
      else $error("o_redirect high two cycles in a row");

   // CC restore rides on a redirect
   restore_with_redirect : assert property (@(posedge clk) disable iff (rst)
      o_cc_restore |-> o_redirect)
      else $error("o_cc_restore without o_redirect");

endmodule

// Attach to every controller instance
bind vic_ctrl vic_properties u_props (
   .clk         (clk),
   .rst         (rst),
   .i_req       (i_req),
   .o_ack       (o_ack),
   .o_redirect  (o_redirect),
   .o_cc_restore(o_cc_restore)
);

`default_nettype wire

/* design/vic_top.sv */
`default_nettype none

`include "vic_cfg.svh"

module vic_top
   import vic_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   // External lines and mask write port
   input  irq_mask_t i_irq,
   input  logic      i_en_we,
   input  irq_mask_t i_en_data,
   // Processor side
   input  addr_t     i_pc,
   input  cc_t       i_cc,
   input  logic      i_not_flush,
   input  logic      i_reti,
   output logic      o_redirect,
   output addr_t     o_target_pc,
   output logic      o_cc_restore,
   output cc_t       o_cc
);

   // Input stage to lines
   irq_mask_t edge_vec;
   irq_mask_t enable_vec;
   // Lines to selector
   irq_mask_t pending_vec;
   // Selector to controller
   logic      req;
   irq_id_t   req_id;
   // Controller acknowledge, broadcast to every line
   logic      ack;
   irq_id_t   ack_id;

   irq_input_stage u_input (
      .clk      (clk),
      .rst      (rst),
      .i_irq    (i_irq),
      .i_en_we  (i_en_we),
      .i_en_data(i_en_data),
      .o_edge   (edge_vec),
      .o_enable (enable_vec)
   );

   // One pending latch per line
   for (genvar k = 0; k < `VIC_NUM_IRQ; k++)
   begin : g_line
      irq_line #(
         .LINE_ID(k)
      ) u_line (
         .clk      (clk),
         .rst      (rst),
         .i_edge   (edge_vec[k]),
         .i_enable (enable_vec[k]),
         .i_ack    (ack),
         .i_ack_id (ack_id),
         .o_pending(pending_vec[k])
      );
   end

   irq_priority u_priority (
      .i_pending(pending_vec),
      .o_req    (req),
      .o_id     (req_id)
   );

   vic_ctrl u_ctrl (
      .clk         (clk),
      .rst         (rst),
      .i_req       (req),
      .i_id        (req_id),
      .i_pc        (i_pc),
      .i_cc        (i_cc),
      .i_not_flush (i_not_flush),
      .i_reti      (i_reti),
      .o_ack       (ack),
      .o_ack_id    (ack_id),
      .o_redirect  (o_redirect),
      .o_target_pc (o_target_pc),
      .o_cc_restore(o_cc_restore),
      .o_cc        (o_cc)
   );

endmodule

`default_nettype wire

/* design/vic_ctrl.sv */
`default_nettype none

`include "vic_cfg.svh"

module vic_ctrl
   import vic_pkg::*;
(
   input  logic    clk,
   input  logic    rst,
   // Request from the priority selector
   input  logic    i_req,
   input  irq_id_t i_id,
   // Processor context at the execute stage
   input  addr_t   i_pc,
   input  cc_t     i_cc,
   // Execute stage holds a real instruction, not a bubble
   input  logic    i_not_flush,
   // Return from interrupt, one cycle pulse
   input  logic    i_reti,
   // Acknowledge back to the lines
   output logic    o_ack,
   output irq_id_t o_ack_id,
   // Fetch redirect
   output logic    o_redirect,
   output addr_t   o_target_pc,
   // Condition code restore on true return
   output logic    o_cc_restore,
   output cc_t     o_cc
);

   vic_state_e state;

   // Context of the interrupted program
   addr_t saved_pc;
   cc_t   saved_cc;

   // Take of a new handler from WAIT_SLOT
   logic take_ok;
   // Accepted return
   logic reti_ok;
   // Return with another line waiting
   logic chain;

   // Handler entry address for a line
   function automatic addr_t vec_addr(input irq_id_t id);
      addr_t offset;
      begin
         offset = addr_t'(id) << `VIC_VEC_SHIFT;
         return addr_t'(`VIC_ISR_BASE) + offset;
      end
   endfunction

   ////////////////////
   // Handshake decode
   ////////////////////

   always_comb
   begin
      // Context is only valid when execute holds a real instruction
      // Request stays up in WAIT_SLOT, nothing acks it there
      take_ok = (state == WAIT_SLOT) && i_not_flush;
      // Ignore a return while the handler's own redirect is still in flight
      reti_ok = (state == IN_ISR) && i_reti && !o_redirect;
      chain   = reti_ok && i_req;
      // Ack names the line presented this cycle
      o_ack    = take_ok || chain;
      o_ack_id = i_id;
   end

   ////////////////////
   // State machine
   ////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state        <= IDLE;
         o_redirect   <= 1'b0;
         o_cc_restore <= 1'b0;
      end
      else
      begin
         // Both are single cycle pulses
         o_redirect   <= 1'b0;
         o_cc_restore <= 1'b0;
         case (state)
            IDLE:
            begin
               if (i_req)
                  state <= WAIT_SLOT;
            end
            WAIT_SLOT:
            begin
               // Stay here as long as execute holds a bubble
               if (take_ok)
               begin
                  state      <= IN_ISR;
                  o_redirect <= 1'b1;
               end
            end
            IN_ISR:
            begin
               if (chain)
               begin
                  // Tail chain, straight into the next handler
                  o_redirect <= 1'b1;
               end
               else if (reti_ok)
               begin
                  state        <= RETURN_WAIT;
                  o_redirect   <= 1'b1;
                  o_cc_restore <= 1'b1;
               end
            end
            RETURN_WAIT:
            begin
               // Restore redirect goes out in this cycle
               state <= IDLE;
            end
            default:
            begin
               state <= IDLE;
            end
         endcase
      end
   end

   ////////////////////
   // Context and target
   ////////////////////

   always_ff @(posedge clk)
   begin
      // Saved once per entry, kept across tail chains
      if (take_ok)
      begin
         saved_pc <= i_pc;
         saved_cc <= i_cc;
      end
      if (o_ack)
         o_target_pc <= vec_addr(i_id);
      else if (reti_ok)
      begin
         // Back to the interrupted program
         o_target_pc <= saved_pc;
         o_cc        <= saved_cc;
      end
   end

endmodule

`default_nettype wire

/* design/irq_priority.sv */
`default_nettype none

`include "vic_cfg.svh"

module irq_priority
   import vic_pkg::*;
(
   // Pending flags from every line
   input  irq_mask_t i_pending,
   // Some line wants service
   output logic      o_req,
   // Winning line, lowest number first
   output irq_id_t   o_id
);

   // Search result
   irq_id_t id_sel;

   ////////////////////
   // Fixed priority
   ////////////////////

   // Walk from the top down so the lowest set bit is written last
   always_comb
   begin
      id_sel = '0;
      for (int i = `VIC_NUM_IRQ - 1; i >= 0; i--)
      begin
         if (i_pending[i])
            id_sel = irq_id_t'(i);
      end
   end

   // Request is any pending line
   assign o_req = |i_pending;
   // Id only meaningful while o_req is high
   assign o_id  = id_sel;

endmodule

`default_nettype wire

/* design/irq_line.sv */
`default_nettype none

module irq_line
   import vic_pkg::*;
#(
   // Index of this line, compared against the acknowledge id
   parameter int LINE_ID = 0
)
(
   input  logic    clk,
   input  logic    rst,
   // Edge pulse and enable bit for this line
   input  logic    i_edge,
   input  logic    i_enable,
   // Broadcast acknowledge from the controller
   input  logic    i_ack,
   input  irq_id_t i_ack_id,
   output logic    o_pending
);

   // Pending latch
   logic pending_q;
   // Acknowledge addressed to this line
   logic ack_hit;
   // Enabled edge seen this cycle
   logic set_req;

   assign ack_hit = i_ack && (i_ack_id == irq_id_t'(LINE_ID));
   assign set_req = i_edge && i_enable;

   // Set wins over clear
   // An edge arriving with its own acknowledge is a new event
   always_ff @(posedge clk)
   begin
      if (rst)
         pending_q <= 1'b0;
      else if (set_req)
         pending_q <= 1'b1;
      else if (ack_hit)
         pending_q <= 1'b0;
   end

   assign o_pending = pending_q;

endmodule

`default_nettype wire

/* design/irq_input_stage.sv */
`default_nettype none

module irq_input_stage
   import vic_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   // Raw asynchronous lines
   input  irq_mask_t i_irq,
   // Mask write port
   input  logic      i_en_we,
   input  irq_mask_t i_en_data,
   // Rising edge pulses, one cycle each
   output irq_mask_t o_edge,
   // Current enable mask
   output irq_mask_t o_enable
);

   ////////////////////
   // Synchronizer
   ////////////////////

   // First and second flop of the per-line synchronizer
   irq_mask_t sync_1;
   irq_mask_t sync_2;
   // Delayed copy for edge detection
   irq_mask_t sync_3;
   // Registered edge pulses
   irq_mask_t edge_q;
   // Enable mask register
   irq_mask_t enable_q;

   // Raw line sampled at t lands in sync_2 at t+1
   // Edge pulse is registered at t+2
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         sync_1 <= '0;
         sync_2 <= '0;
         sync_3 <= '0;
         edge_q <= '0;
      end
      else
      begin
         sync_1 <= i_irq;
         sync_2 <= sync_1;
         sync_3 <= sync_2;
         // Rising edge, new level high and old level low
         edge_q <= sync_2 & ~sync_3;
      end
   end

   ////////////////////
   // Enable mask
   ////////////////////

   // All lines masked out of reset
   always_ff @(posedge clk)
   begin
      if (rst)
         enable_q <= '0;
      else if (i_en_we)
         enable_q <= i_en_data;
   end

   assign o_edge   = edge_q;
   assign o_enable = enable_q;

endmodule

`default_nettype wire

/* design/vic_pkg.sv */
`default_nettype none

`include "vic_cfg.svh"

package vic_pkg;

   // Instruction address as seen by fetch
   typedef logic [31:0] addr_t;
   // Processor condition codes
   typedef logic [3:0] cc_t;
   // Interrupt line number
   typedef logic [$clog2(`VIC_NUM_IRQ)-1:0] irq_id_t;
   // One bit per interrupt line
   typedef logic [`VIC_NUM_IRQ-1:0] irq_mask_t;

   // Controller states
   typedef enum logic [1:0] {
      IDLE,
      WAIT_SLOT,
      IN_ISR,
      RETURN_WAIT
   } vic_state_e;

endpackage

`default_nettype wire

/* design/vic_cfg.svh */
`ifndef VIC_CFG_SVH
`define VIC_CFG_SVH

////////////////////
// Interrupt lines
////////////////////

// Number of external lines, a power of two up to 32
`define VIC_NUM_IRQ 8

////////////////////
// Vector table
////////////////////

// Byte address of the handler for line 0
`define VIC_ISR_BASE 32'h0000_0100
// Log2 of handler slot size, 16 bytes per slot
`define VIC_VEC_SHIFT 4

`endif
